// ==== tim.f ====
+incdir+hdl
hdl/mem_pkg.sv
hdl/tim_pkg.sv
hdl/tim_bank.sv
hdl/tim_front.sv
hdl/tim_back.sv
hdl/tim.sv
sim/tim_clock_gen.sv
sim/tim_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tim testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tim.f --top-module tim_tb -o tim_sim

# the simulation exits nonzero on failure, the search decides the result.
output=$(./obj_dir/tim_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi

// ==== sim/tim_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tim_params.svh"

module tim_tb;

  import mem_pkg::*;
  import tim_pkg::*;

  localparam int period       = 40;
  localparam int unsigned words = `TIM_WIDTH * `TIM_DEPTH; // word addresses before aliasing.

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    word_t       wdata;
    strb_t       wstrb;
  } entry_t;

  logic        clock;
  logic        reset;
  logic        valid;
  logic [31:0] addr;
  word_t       wdata;
  strb_t       wstrb;
  word_t       rdata;
  logic        ready;

  entry_t stim [$];
  entry_t idle_entry;
  logic   stim_built = 1'b0;

  // reference memory updated as soon as a write is driven.
  word_t model [words];
  word_t exp_rdata;
  logic  exp_ready;

  tim_clock_gen i_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  tim i_tim (
    .clock (clock),
    .reset (reset),
    .valid (valid),
    .addr  (addr),
    .wdata (wdata),
    .wstrb (wstrb),
    .rdata (rdata),
    .ready (ready)
  );

  // **********************************************************************
  // reference model.
  // **********************************************************************

  function automatic int word_key(logic [31:0] a);
    return int'((a >> 2) % words); // upper bits alias.
  endfunction

  function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strobes);
    word_t mask;
    for (int b = 0; b < $bits(strb_t); b++) begin
      mask[8*b +: 8] = {8{strobes[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // **********************************************************************
  // checks.
  // **********************************************************************

  task automatic check_word(input word_t actual, input word_t expected, input string name);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string name);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // **********************************************************************
  // stimulus.
  // **********************************************************************

  task automatic add_entry(input logic v, input logic [31:0] a, input word_t d, input strb_t s);
    entry_t e;
    e.valid = v;
    e.addr  = a;
    e.wdata = d;
    e.wstrb = s;
    stim.push_back(e);
  endtask

  task automatic build_directed();
    // valid  addr           wdata          wstrb
    add_entry(1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000); // idle.
    add_entry(1'b1, 32'h0000_0100, 32'hdead_beef, 4'b1111); // full write.
    add_entry(1'b1, 32'h0000_0100, 32'h0000_0000, 4'b0000); // forwarded read.
    add_entry(1'b0, 32'h0000_0100, 32'hffff_ffff, 4'b1111); // idle with strobes set.
    add_entry(1'b1, 32'h0000_0100, 32'h0000_0000, 4'b0000);
    add_entry(1'b1, 32'h0000_0102, 32'h0000_0000, 4'b0000); // byte offset ignored.
    add_entry(1'b1, 32'h0000_0900, 32'h0000_0000, 4'b0000); // aliases 0x100.
    add_entry(1'b1, 32'h0000_03fc, 32'h0000_0000, 4'b0000); // never written.
    add_entry(1'b1, 32'h0000_0200, 32'h1122_3344, 4'b1111);
    add_entry(1'b1, 32'h0000_0200, 32'haaaa_aa55, 4'b0001); // back-to-back partials.
    add_entry(1'b1, 32'h0000_0200, 32'hcc00_0000, 4'b1000);
    add_entry(1'b1, 32'h0000_0200, 32'h0000_0000, 4'b0000);
    add_entry(1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000);
    add_entry(1'b1, 32'h0000_0200, 32'h0077_6600, 4'b0110);
    add_entry(1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000);
    add_entry(1'b1, 32'h0000_0200, 32'h0000_0000, 4'b0000);
    add_entry(1'b1, 32'h0000_0020, 32'h0000_aaaa, 4'b1111); // bank 0 index 4.
    add_entry(1'b1, 32'h0000_0024, 32'h5555_bbbb, 4'b1111); // bank 1 index 4.
    add_entry(1'b1, 32'h0000_0020, 32'h0000_0000, 4'b0000);
    add_entry(1'b1, 32'h0000_0024, 32'h0000_0000, 4'b0000);
    add_entry(1'b1, 32'h0000_0020, 32'h0000_0000, 4'b0000);
    add_entry(1'b1, 32'h0000_0024, 32'h0000_0000, 4'b0000);
    add_entry(1'b1, 32'h0000_0024, 32'h0000_00ee, 4'b0001);
    add_entry(1'b1, 32'h0000_0020, 32'h0000_0000, 4'b0000); // other bank untouched.
    add_entry(1'b1, 32'h0000_0024, 32'h0000_0000, 4'b0000);
    add_entry(1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000);
    add_entry(1'b1, 32'h0000_0100, 32'h0000_0000, 4'b0000);
    add_entry(1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000);
  endtask

  // small address window so the same words are hit again.
  task automatic build_random(input int count);
    entry_t e;
    int unsigned word_sel;
    int unsigned offset;
    for (int n = 0; n < count; n++) begin
      e.valid  = ($urandom % 4) != 0;
      word_sel = $urandom % 8;
      offset   = $urandom % 4;
      e.addr   = (word_sel << 2) | offset;
      e.wdata  = word_t'($urandom);
      if ($urandom % 2) begin
        e.wstrb = strb_t'($urandom);
      end else begin
        e.wstrb = '0;
      end
      stim.push_back(e);
    end
  endtask

  task automatic drive_entry(input entry_t e);
    int key;
    key   = word_key(e.addr);
    valid = e.valid;
    addr  = e.addr;
    wdata = e.wdata;
    wstrb = e.wstrb;
    if (!e.valid) begin
      exp_ready = 1'b0;
      exp_rdata = '0;
    end else if (e.wstrb != '0) begin
      model[key] = merge_bytes(model[key], e.wdata, e.wstrb);
      exp_ready  = 1'b1;
      exp_rdata  = '0; // writes answer with zero.
    end else begin
      exp_ready = 1'b1;
      exp_rdata = model[key];
    end
  endtask

  // **********************************************************************
  // run.
  // **********************************************************************

  initial begin
    void'($urandom(93));
    valid = 1'b0;
    addr  = '0;
    wdata = '0;
    wstrb = '0;
    idle_entry = '0;
    for (int k = 0; k < int'(words); k++) begin
      model[k] = '0;
    end
    build_directed();
    build_random(40);
    stim_built = 1'b1;

    @(posedge clock);
    repeat (2) begin
      #1;
      check_flag(ready, 1'b0, "ready"); // quiet while in reset.
      check_word(rdata, '0, "rdata");
      @(posedge clock);
    end
    wait (reset === 1'b1);

    // each response is checked one edge after its request.
    for (int i = 0; i <= stim.size(); i++) begin
      @(posedge clock);
      #1;
      if (i > 0) begin
        check_word(rdata, exp_rdata, "rdata");
        check_flag(ready, exp_ready, "ready");
      end
      if (i < stim.size()) begin
        drive_entry(stim[i]);
      end else begin
        drive_entry(idle_entry);
      end
    end
    @(posedge clock);
    #1;
    check_word(rdata, exp_rdata, "rdata");
    check_flag(ready, exp_ready, "ready");

    $display("All checks passed");
    $finish;
  end

  initial begin
    wait (stim_built === 1'b1);
    #((stim.size() + 10) * period);
    $display("timeout: the run did not finish in the expected time");
    $display("Checks failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// ==== sim/tim_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tim_clock_gen (
  output logic clock,
  output logic reset
);

  localparam int half_period  = 20; // 40 ns clock.
  localparam int reset_cycles = 3;

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  // reset held low for the first edges, released just after one.
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hdl/tim.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tim_params.svh"

module tim (
  input  logic           clock,
  input  logic           reset,
  input  logic           valid,
  input  logic [31:0]    addr,
  input  mem_pkg::word_t wdata,
  input  mem_pkg::strb_t wstrb,
  output mem_pkg::word_t rdata,
  output logic           ready
);

  import mem_pkg::*;
  import tim_pkg::*;

  // front stage to back stage.
  mem_op_t   f_op;
  bank_sel_t f_bank;
  word_idx_t f_index;
  word_t     f_data;
  strb_t     f_strb;

  // bank side.
  word_idx_t rd_index;
  bank_en_t  wen;
  word_idx_t waddr;
  word_t     bank_wdata;
  word_t     bank_rdata [`TIM_WIDTH];

  tim_front i_front (
    .clock    (clock),
    .reset    (reset),
    .valid    (valid),
    .addr     (addr),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .op       (f_op),
    .bank     (f_bank),
    .index    (f_index),
    .data     (f_data),
    .strb     (f_strb),
    .rd_index (rd_index)
  );

  // every bank reads the same index, the back stage picks one.
  for (genvar i = 0; i < `TIM_WIDTH; i++) begin : g_bank
    tim_bank i_bank (
      .clock (clock),
      .wen   (wen[i]),
      .waddr (waddr),
      .wdata (bank_wdata),
      .raddr (rd_index),
      .rdata (bank_rdata[i])
    );
  end

  tim_back i_back (
    .clock      (clock),
    .reset      (reset),
    .op         (f_op),
    .bank       (f_bank),
    .index      (f_index),
    .data       (f_data),
    .strb       (f_strb),
    .bank_rdata (bank_rdata),
    .wen        (wen),
    .waddr      (waddr),
    .wdata      (bank_wdata),
    .rdata      (rdata),
    .ready      (ready)
  );

endmodule

`default_nettype wire

// ==== hdl/tim_back.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tim_params.svh"

module tim_back (
  input  logic               clock,
  input  logic               reset,
  input  mem_pkg::mem_op_t   op,
  input  tim_pkg::bank_sel_t bank,
  input  tim_pkg::word_idx_t index,
  input  mem_pkg::word_t     data,
  input  mem_pkg::strb_t     strb,
  input  mem_pkg::word_t     bank_rdata [`TIM_WIDTH],
  output tim_pkg::bank_en_t  wen,
  output tim_pkg::word_idx_t waddr,
  output mem_pkg::word_t     wdata,
  output mem_pkg::word_t     rdata,
  output logic               ready
);

  import mem_pkg::*;
  import tim_pkg::*;

  // last write still in flight to its bank.
  logic      last_valid;
  bank_sel_t last_bank;
  word_idx_t last_index;
  word_t     last_word;

  logic  fwd_hit;
  word_t cur_word;
  word_t merged;

  // **********************************************************************
  // current word.
  // **********************************************************************

  assign fwd_hit = last_valid && (last_bank == bank) && (last_index == index);

  // bank output is stale right after a write to the same word.
  assign cur_word = fwd_hit ? last_word : bank_rdata[bank];

  always_comb begin
    merged = cur_word;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
  end

  // **********************************************************************
  // write-back.
  // **********************************************************************

  always_comb begin
    wen = '0;
    if (op == op_write) begin
      wen[bank] = 1'b1;
    end
  end

  assign waddr = index; // shared by all banks.
  assign wdata = merged;

  always_ff @(posedge clock) begin
    if (!reset) begin
      last_valid <= 1'b0;
    end else begin
      last_valid <= (op == op_write);
    end
  end

  always_ff @(posedge clock) begin
    if (op == op_write) begin
      last_bank  <= bank;
      last_index <= index;
      last_word  <= merged;
    end
  end

  // **********************************************************************
  // response.
  // **********************************************************************

  assign rdata = (op == op_read) ? cur_word : '0;
  assign ready = (op != op_idle); // one pulse per request.

  // a read right behind a write to the same word sees the merged word.
  a_fwd_read : assert property (@(posedge clock) disable iff (!reset)
    op == op_read && $past(op) == op_write && $past(bank) == bank
    && $past(index) == index |-> rdata == $past(wdata));

endmodule

`default_nettype wire

// ==== hdl/tim_front.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tim_params.svh"

module tim_front (
  input  logic               clock,
  input  logic               reset,
  input  logic               valid,
  input  logic [31:0]        addr,
  input  mem_pkg::word_t     wdata,
  input  mem_pkg::strb_t     wstrb,
  output mem_pkg::mem_op_t   op,
  output tim_pkg::bank_sel_t bank,
  output tim_pkg::word_idx_t index,
  output mem_pkg::word_t     data,
  output mem_pkg::strb_t     strb,
  output tim_pkg::word_idx_t rd_index
);

  import mem_pkg::*;
  import tim_pkg::*;

  localparam int bank_lsb  = 2; // byte offset skipped.
  localparam int index_lsb = bank_lsb + bank_bits;

  mem_op_t   next_op;
  bank_sel_t next_bank;
  word_idx_t next_index;

  // **********************************************************************
  // decode.
  // **********************************************************************

  always_comb begin
    if (!valid) begin
      next_op = op_idle;
    end else if (|wstrb) begin
      next_op = op_write;
    end else begin
      next_op = op_read;
    end
  end

  assign next_bank  = addr[index_lsb-1:bank_lsb]; // interleave on word address.
  assign next_index = addr[index_lsb+index_bits-1:index_lsb];

  // banks start their read at the same edge this stage registers.
  assign rd_index = next_index;

  // **********************************************************************
  // request register.
  // **********************************************************************

  always_ff @(posedge clock) begin
    if (!reset) begin
      op <= op_idle;
    end else begin
      op <= next_op;
    end
  end

  always_ff @(posedge clock) begin
    if (valid) begin
      bank  <= next_bank;
      index <= next_index;
      data  <= wdata;
      strb  <= wstrb;
    end
  end

  // an offered request must carry a known address and strobes.
  a_req_known : assert property (@(posedge clock) disable iff (!reset)
    valid |-> !$isunknown({addr, wstrb}));

endmodule

`default_nettype wire

// ==== hdl/tim_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tim_params.svh"

module tim_bank (
  input  logic               clock,
  input  logic               wen,
  input  tim_pkg::word_idx_t waddr,
  input  mem_pkg::word_t     wdata,
  input  tim_pkg::word_idx_t raddr,
  output mem_pkg::word_t     rdata
);

  import mem_pkg::*;

  // contents power up cleared.
  word_t mem [`TIM_DEPTH] = '{default: '0};

  always_ff @(posedge clock) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr]; // old word on a same-address write.
  end

  // a stray write enable would corrupt the bank.
  a_wen_known : assert property (@(posedge clock) !$isunknown(wen));

endmodule

`default_nettype wire

// ==== hdl/tim_pkg.sv ====
`default_nettype none

`include "tim_params.svh"

package tim_pkg;

  // address split below the byte offset.
  localparam int bank_bits  = $clog2(`TIM_WIDTH);
  localparam int index_bits = $clog2(`TIM_DEPTH);

  // bank number, taken from the low word address bits.
  typedef logic [bank_bits-1:0] bank_sel_t;

  // word index inside one bank.
  typedef logic [index_bits-1:0] word_idx_t;

  // one write enable per bank.
  typedef logic [`TIM_WIDTH-1:0] bank_en_t;

endpackage

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

`include "tim_params.svh"

package mem_pkg;

  // one bus word.
  typedef logic [`TIM_DATA-1:0] word_t;

  // one write strobe per byte lane.
  typedef logic [`TIM_DATA/8-1:0] strb_t;

  // kind of request held in a pipeline stage.
  typedef enum logic [1:0] {
    op_idle,   // nothing to answer.
    op_read,
    op_write   // at least one strobe set.
  } mem_op_t;

endpackage

`default_nettype wire

// ==== hdl/tim_params.svh ====
`ifndef TIM_PARAMS_SVH
`define TIM_PARAMS_SVH

// **********************************************************************
// memory geometry.
// **********************************************************************

// number of word-interleaved banks, a power of two.
`define TIM_WIDTH 2

// words held by each bank, a power of two.
`define TIM_DEPTH 256

// **********************************************************************
// bus geometry.
// **********************************************************************

// bus word width in bits, whole bytes only.
`define TIM_DATA 32

`endif
